//--- acqSequencer.sv
`timescale 1ns/10ps
`default_nettype none

module acqSequencer import hisPkg::*; #(
    parameter int binW = DEF_BIN_W,
    parameter int pixelNum = DEF_PIXELS,
    parameter int sampleNum = DEF_SAMPLES,
    parameter int acqNum = DEF_ACQS,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1,
    localparam int smpW = (sampleNum > 1) ? $clog2(sampleNum) : 1,
    localparam int acqW = (acqNum > 1) ? $clog2(acqNum) : 1
) (
    input  logic            clk,
    input  logic            combin_res,
    input  logic            wrEn,
    input  logic [binW-1:0] addr,
    input  logic            readDone,
    output logic            busy,
    output logic            readStart,
    sampleIf.master         smp
);

    seqState_t       state;
    logic [smpW-1:0] smpCnt;
    logic [pixW-1:0] pixCnt;
    logic [acqW-1:0] acqCnt;
    // second cycle of DRAIN or CLEAR
    logic            waitCnt;
    logic            accept;
    logic            lastSmp;
    logic            lastPix;
    logic            lastAcq;

    // only COLLECT takes samples
    assign busy = (state != COLLECT);
    // dropped while busy, never counted
    assign accept = wrEn && !busy;

    assign lastSmp = (smpCnt == smpW'(sampleNum - 1));
    assign lastPix = (pixCnt == pixW'(pixelNum - 1));
    assign lastAcq = (acqCnt == acqW'(acqNum - 1));

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            state     <= COLLECT;
            smpCnt    <= '0;
            pixCnt    <= '0;
            acqCnt    <= '0;
            waitCnt   <= 1'b0;
            readStart <= 1'b0;
            smp.valid <= 1'b0;
            smp.clear <= 1'b0;
        end else begin
            // strobes default low
            smp.valid <= accept;
            readStart <= 1'b0;
            smp.clear <= 1'b0;
            case (state)
                COLLECT: begin
                    if (accept) begin
                        if (!lastSmp) begin
                            smpCnt <= smpCnt + 1'b1;
                        end else begin
                            smpCnt <= '0;
                            if (!lastPix) begin
                                pixCnt <= pixCnt + 1'b1;
                            end else begin
                                pixCnt <= '0;
                                if (!lastAcq) begin
                                    acqCnt <= acqCnt + 1'b1;
                                end else begin
                                    // set complete, all counters wrap to zero
                                    acqCnt <= '0;
                                    state  <= DRAIN;
                                end
                            end
                        end
                    end
                end
                DRAIN: begin
                    // two cycles for the last sample to reach the tracker
                    waitCnt <= !waitCnt;
                    if (waitCnt) begin
                        state     <= READOUT;
                        readStart <= 1'b1;
                    end
                end
                READOUT: begin
                    if (readDone) begin
                        state     <= CLEAR;
                        smp.clear <= 1'b1;
                    end
                end
                CLEAR: begin
                    // memory clears first, tracker one cycle later
                    waitCnt <= !waitCnt;
                    if (waitCnt) begin
                        state <= COLLECT;
                    end
                end
                default: begin
                    state <= COLLECT;
                end
            endcase
        end
    end

    // sample payload, qualified by smp.valid
    always_ff @(posedge clk) begin
        smp.addr  <= addr;
        smp.pixel <= pixCnt;
    end

endmodule

`default_nettype wire

//--- binMemory.sv
`timescale 1ns/10ps
`default_nettype none

module binMemory import hisPkg::*; #(
    parameter int binW = DEF_BIN_W,
    parameter int countW = DEF_COUNT_W,
    parameter int pixelNum = DEF_PIXELS,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1,
    localparam int depth = pixelNum * (2 ** binW)
) (
    input  logic    clk,
    input  logic    combin_res,
    sampleIf.slave  smp,
    binIf.master    bin
);

    // one counter per bin of each pixel
    logic [countW-1:0]    mem [depth];
    // bin touched since the last clear
    logic [depth-1:0]     used;
    logic [pixW+binW-1:0] idx;
    logic [countW-1:0]    newCount;

    // pixel times bins per pixel plus address
    assign idx = {smp.pixel, smp.addr};

    // unused bin starts at one, stale contents ignored
    assign newCount = used[idx] ? mem[idx] + 1'b1 : countW'(1);

    // read and write hit the same register, back to back samples chain
    always_ff @(posedge clk) begin
        if (smp.valid) begin
            mem[idx] <= newCount;
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            used <= '0;
        end else if (smp.clear) begin
            // whole histogram empties at once
            used <= '0;
        end else if (smp.valid) begin
            used[idx] <= 1'b1;
        end
    end

    // strobes toward the tracker
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            bin.valid <= 1'b0;
            bin.clear <= 1'b0;
        end else begin
            bin.valid <= smp.valid;
            bin.clear <= smp.clear;
        end
    end

    // new count with its bin and pixel
    always_ff @(posedge clk) begin
        bin.addr  <= smp.addr;
        bin.pixel <= smp.pixel;
        bin.count <= newCount;
    end

endmodule

`default_nettype wire

//--- hisBuilder.sv
`timescale 1ns/10ps
`default_nettype none

module hisBuilder import hisPkg::*; #(
    parameter int binW = DEF_BIN_W,
    parameter int countW = DEF_COUNT_W,
    parameter int fineW = DEF_FINE_W,
    parameter int pixelNum = DEF_PIXELS,
    parameter int sampleNum = DEF_SAMPLES,
    parameter int acqNum = DEF_ACQS,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              wrEn,
    input  logic [binW-1:0]   addr,
    output logic              busy,
    output logic              peakValid,
    output logic [pixW-1:0]   peakPixel,
    output logic [binW-1:0]   peakBin,
    output logic [countW-1:0] peakCount,
    output logic [fineW-1:0]  windowLow
);

    // readout handshake and tracker read port
    logic              readStart;
    logic              readDone;
    logic [pixW-1:0]   rdPixel;
    logic [binW-1:0]   rdBin;
    logic [countW-1:0] rdCount;

    sampleIf #(.binW(binW), .pixelNum(pixelNum)) smpBus ();
    binIf #(.binW(binW), .countW(countW), .pixelNum(pixelNum)) binBus ();

    // counters, state and clear command
    acqSequencer #(
        .binW(binW), .pixelNum(pixelNum), .sampleNum(sampleNum), .acqNum(acqNum)
    ) uSeq (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .addr(addr),
        .readDone(readDone), .busy(busy), .readStart(readStart), .smp(smpBus.master)
    );

    // histogram counters
    binMemory #(.binW(binW), .countW(countW), .pixelNum(pixelNum)) uMem (
        .clk(clk), .combin_res(combin_res), .smp(smpBus.slave), .bin(binBus.master)
    );

    // per pixel peak
    peakTracker #(.binW(binW), .countW(countW), .pixelNum(pixelNum)) uTrack (
        .clk(clk), .combin_res(combin_res), .rdPixel(rdPixel),
        .rdBin(rdBin), .rdCount(rdCount), .bin(binBus.slave)
    );

    // pixel walk and window edge
    peakReadout #(
        .binW(binW), .countW(countW), .fineW(fineW), .pixelNum(pixelNum)
    ) uRead (
        .clk(clk), .combin_res(combin_res), .readStart(readStart),
        .rdBin(rdBin), .rdCount(rdCount), .rdPixel(rdPixel), .readDone(readDone),
        .peakValid(peakValid), .peakPixel(peakPixel), .peakBin(peakBin),
        .peakCount(peakCount), .windowLow(windowLow)
    );

endmodule

`default_nettype wire

//--- hisBuilderTb.sv
`timescale 1ns/10ps
`default_nettype none

module hisBuilderTb import hisPkg::*; ();

    localparam int binW = DEF_BIN_W;
    localparam int countW = DEF_COUNT_W;
    localparam int fineW = DEF_FINE_W;
    localparam int pixelNum = DEF_PIXELS;
    localparam int sampleNum = DEF_SAMPLES;
    localparam int acqNum = DEF_ACQS;
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1;
    localparam int binCount = 2 ** binW;
    localparam int setLen = acqNum * pixelNum * sampleNum;
    // samples, drain, readout walk, clear and some slack
    localparam int setCycles = setLen + pixelNum + 8;
    // reset plus eight sets over all tests, four times over
    localparam int maxCycles = 4 * (8 + 8 * setCycles);
    localparam int readLimit = 16;

    logic              clk = 1'b0;
    logic              combin_res;
    logic              wrEn;
    logic [binW-1:0]   addr;
    logic              busy;
    logic              peakValid;
    logic [pixW-1:0]   peakPixel;
    logic [binW-1:0]   peakBin;
    logic [countW-1:0] peakCount;
    logic [fineW-1:0]  windowLow;

    int                errors;
    int                cycles;
    int                seed;
    logic [binW-1:0]   setAddr [setLen];
    // reference histograms and peaks
    int                mHist [pixelNum][binCount];
    logic [countW-1:0] mCnt [pixelNum];
    logic [binW-1:0]   mBin [pixelNum];

    hisBuilder #(
        .binW(binW), .countW(countW), .fineW(fineW),
        .pixelNum(pixelNum), .sampleNum(sampleNum), .acqNum(acqNum)
    ) i_dut (
        .clk(clk), .combin_res(combin_res), .wrEn(wrEn), .addr(addr),
        .busy(busy), .peakValid(peakValid), .peakPixel(peakPixel),
        .peakBin(peakBin), .peakCount(peakCount), .windowLow(windowLow)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= maxCycles) begin
            $display("run stopped after %0d cycles without finishing", cycles);
            $display("Test failed");
            $finish;
        end
    end

    task automatic checkPixel(input string name, input logic [pixW-1:0] exp,
                              input logic [pixW-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkBin(input string name, input logic [binW-1:0] exp,
                            input logic [binW-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkCount(input string name, input logic [countW-1:0] exp,
                              input logic [countW-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    task automatic checkFine(input string name, input logic [fineW-1:0] exp,
                             input logic [fineW-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("[FAIL] %0t %s expected %0d actual %0d", $time, name, exp, act);
        end
    endtask

    // pixel of the k-th sample in a set
    function automatic int pixelOf(input int k);
        return (k / sampleNum) % pixelNum;
    endfunction

    // acquisition of the k-th sample
    function automatic int acqOf(input int k);
        return k / (pixelNum * sampleNum);
    endfunction

    // fine window lower edge around a peak bin
    function automatic logic [fineW-1:0] windowOf(input logic [binW-1:0] b);
        int centre;
        int half;
        int lowEdge;
        centre = int'(b) << (fineW - binW);
        half = 1 << (binW - 1);
        if (centre <= half) begin
            lowEdge = 0;
        end else if (centre + half > (1 << fineW) - 1) begin
            lowEdge = (1 << fineW) - 2 * half;
        end else begin
            lowEdge = centre - half;
        end
        return fineW'(lowEdge);
    endfunction

    task automatic clearModel();
        int p;
        int b;
        for (p = 0; p < pixelNum; p++) begin
            mCnt[p] = '0;
            mBin[p] = '0;
            for (b = 0; b < binCount; b++) begin
                mHist[p][b] = 0;
            end
        end
    endtask

    // peak moves only on a strictly greater count
    task automatic modelSample(input int p, input logic [binW-1:0] a);
        mHist[p][a]++;
        if (mHist[p][a] > int'(mCnt[p])) begin
            mCnt[p] = countW'(mHist[p][a]);
            mBin[p] = a;
        end
    endtask

    // expects peakValid for pixelNum cycles in pixel order
    task automatic collectReadout();
        int p;
        int waited;
        waited = 0;
        while (!peakValid && waited < readLimit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (!peakValid) begin
            errors++;
            $display("no peakValid within %0d cycles after the set", readLimit);
            return;
        end
        for (p = 0; p < pixelNum; p++) begin
            if (!peakValid) begin
                errors++;
                $display("peakValid low at pixel %0d of the readout", p);
            end
            checkPixel("peakPixel", pixW'(p), peakPixel);
            checkBin("peakBin", mBin[p], peakBin);
            checkCount("peakCount", mCnt[p], peakCount);
            checkFine("windowLow", windowOf(mBin[p]), windowLow);
            @(posedge clk);
            #2;
        end
        if (peakValid) begin
            errors++;
            $display("peakValid still high after the last pixel");
        end
    endtask

    // wrEn drops as soon as busy falls, so nothing slips in
    task automatic waitIdle();
        int waited;
        waited = 0;
        while (busy && waited < readLimit) begin
            @(posedge clk);
            #2;
            waited++;
        end
        wrEn = 1'b0;
        if (busy) begin
            errors++;
            $display("busy did not fall after the readout");
        end
    endtask

    // one full set from setAddr, then readout and clear
    task automatic runSet(input logic holdWr);
        int k;
        clearModel();
        for (k = 0; k < setLen; k++) begin
            if (busy) begin
                errors++;
                $display("busy high during sample %0d, sample lost", k);
            end else begin
                modelSample(pixelOf(k), setAddr[k]);
            end
            wrEn = 1'b1;
            addr = setAddr[k];
            @(posedge clk);
            #2;
        end
        // optional writes during busy, all to the top bin
        wrEn = holdWr;
        addr = '1;
        collectReadout();
        waitIdle();
    endtask

    task automatic testReset();
        int k;
        if (busy !== 1'b0 || peakValid !== 1'b0) begin
            errors++;
            $display("busy or peakValid not low after reset");
        end
        for (k = 0; k < setLen; k++) begin
            setAddr[k] = '0;
        end
        runSet(1'b0);
    endtask

    // two samples at p+2 and one at p+9 per acquisition
    task automatic testPeaks();
        int k;
        for (k = 0; k < setLen; k++) begin
            if (k % sampleNum == sampleNum - 1) begin
                setAddr[k] = binW'(pixelOf(k) + 9);
            end else begin
                setAddr[k] = binW'(pixelOf(k) + 2);
            end
        end
        runSet(1'b0);
    endtask

    // every pixel ends with tied bins, first to reach wins
    task automatic testTies();
        int k;
        logic [binW-1:0] tieTab [pixelNum][2 * sampleNum];
        tieTab = '{'{5, 9, 5, 9, 2, 2}, '{3, 7, 7, 3, 0, 0},
                   '{12, 12, 4, 4, 4, 12}, '{1, 2, 3, 3, 2, 1}};
        for (k = 0; k < setLen; k++) begin
            setAddr[k] = tieTab[pixelOf(k)][acqOf(k) * sampleNum + k % sampleNum];
        end
        runSet(1'b0);
    endtask

    // low clamp at bin 0, middle bin, top bin
    task automatic testWindow();
        int k;
        logic [binW-1:0] peakTab [pixelNum];
        peakTab = '{0, 8, 15, 1};
        for (k = 0; k < setLen; k++) begin
            setAddr[k] = peakTab[pixelOf(k)];
        end
        runSet(1'b0);
    endtask

    // writes held during busy, second set must not see them
    task automatic testDropClear();
        int k;
        for (k = 0; k < setLen; k++) begin
            setAddr[k] = binW'(pixelOf(k) + 4);
        end
        runSet(1'b1);
        for (k = 0; k < setLen; k++) begin
            if (k % sampleNum == 0) begin
                setAddr[k] = binW'(pixelOf(k) + 4);
            end else begin
                setAddr[k] = binW'(pixelOf(k) + 8);
            end
        end
        runSet(1'b0);
    endtask

    task automatic testRandom();
        int k;
        int n;
        for (n = 0; n < 2; n++) begin
            for (k = 0; k < setLen; k++) begin
                setAddr[k] = binW'($random(seed));
            end
            runSet(1'b0);
        end
    endtask

    initial begin
        seed = 76;
        errors = 0;
        cycles = 0;
        combin_res = 1'b0;
        wrEn = 1'b0;
        addr = '0;
        repeat (8) @(posedge clk);
        #2;
        combin_res = 1'b1;
        @(posedge clk);
        #2;
        testReset();
        testPeaks();
        testTies();
        testWindow();
        testDropClear();
        testRandom();
        $display("checks done with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hisBuilder_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module hisBuilder_assertions #(
    parameter int pixW = 2
) (
    input logic            clk,
    input logic            combin_res,
    input logic            busy,
    input logic            peakValid,
    input logic [pixW-1:0] peakPixel
);

    // idle in reset and on the first edge after it
    resetIdle: assert property (@(posedge clk)
        (!combin_res || $rose(combin_res)) |-> (!busy && !peakValid))
        else $error("busy or peakValid high around reset");

    // results only inside the busy window
    validInBusy: assert property (@(posedge clk) disable iff (!combin_res)
        peakValid |-> busy)
        else $error("peakValid high while not busy");

    // readout walks pixels one by one
    pixelStep: assert property (@(posedge clk) disable iff (!combin_res)
        (peakValid && $past(peakValid)) |-> (peakPixel == pixW'($past(peakPixel) + 1'b1)))
        else $error("peakPixel skipped between readout cycles");

endmodule

bind hisBuilder hisBuilder_assertions #(.pixW(pixW)) uAssert (
    .clk(clk), .combin_res(combin_res), .busy(busy),
    .peakValid(peakValid), .peakPixel(peakPixel)
);

`default_nettype wire

//--- hisIf.sv
`timescale 1ns/10ps
`default_nettype none

// accepted sample, sequencer to bin memory
interface sampleIf import hisPkg::*; #(
    parameter int binW = DEF_BIN_W,
    parameter int pixelNum = DEF_PIXELS,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
);
    logic            valid;
    logic [binW-1:0] addr;
    logic [pixW-1:0] pixel;
    logic            clear;

    modport master (output valid, addr, pixel, clear);
    modport slave (input valid, addr, pixel, clear);
endinterface

// updated bin, bin memory to peak tracker
interface binIf import hisPkg::*; #(
    parameter int binW = DEF_BIN_W,
    parameter int countW = DEF_COUNT_W,
    parameter int pixelNum = DEF_PIXELS,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
);
    logic              valid;
    logic [binW-1:0]   addr;
    logic [pixW-1:0]   pixel;
    logic [countW-1:0] count;
    // clear one cycle behind the sample bus
    logic              clear;

    modport master (output valid, addr, pixel, count, clear);
    modport slave (input valid, addr, pixel, count, clear);
endinterface

`default_nettype wire

//--- hisPkg.sv
`default_nettype none

package hisPkg;

    // sequencer phases
    // COLLECT takes samples, the rest keep busy high
    typedef enum logic [1:0] {
        COLLECT,
        DRAIN,
        READOUT,
        CLEAR
    } seqState_t;

    // bin address width, 16 bins per pixel
    localparam int DEF_BIN_W = 4;

    // width of one bin counter
    localparam int DEF_COUNT_W = 8;

    // fine position width for the window edge
    localparam int DEF_FINE_W = 8;

    // pixels per acquisition
    localparam int DEF_PIXELS = 4;

    // samples per pixel per acquisition
    localparam int DEF_SAMPLES = 3;

    // acquisitions per histogram set
    localparam int DEF_ACQS = 2;

endpackage

`default_nettype wire

//--- peakReadout.sv
`timescale 1ns/10ps
`default_nettype none

module peakReadout import hisPkg::*; #(
    parameter int binW = DEF_BIN_W,
    parameter int countW = DEF_COUNT_W,
    parameter int fineW = DEF_FINE_W,
    parameter int pixelNum = DEF_PIXELS,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic              clk,
    input  logic              combin_res,
    input  logic              readStart,
    input  logic [binW-1:0]   rdBin,
    input  logic [countW-1:0] rdCount,
    output logic [pixW-1:0]   rdPixel,
    output logic              readDone,
    output logic              peakValid,
    output logic [pixW-1:0]   peakPixel,
    output logic [binW-1:0]   peakBin,
    output logic [countW-1:0] peakCount,
    output logic [fineW-1:0]  windowLow
);

    // one extra bit so centre plus half width cannot wrap
    localparam int fw1 = fineW + 1;
    localparam int halfW = 2 ** (binW - 1);
    localparam int fineMax = 2 ** fineW - 1;
    localparam int topEdge = 2 ** fineW - 2 * halfW;
    localparam logic [pixW-1:0] lastPix = pixW'(pixelNum - 1);

    logic           active;
    logic           step;
    logic [fw1-1:0] centre;
    logic [fineW-1:0] edgeLow;

    // readStart covers pixel 0, active the rest
    assign step = readStart || active;

    // peak bin scaled to fine resolution
    assign centre = fw1'(rdBin) << (fineW - binW);

    // window lower edge, clamped at both ends
    always_comb begin
        if (centre <= fw1'(halfW)) begin
            edgeLow = '0;
        end else if ((centre + fw1'(halfW)) > fw1'(fineMax)) begin
            edgeLow = fineW'(topEdge);
        end else begin
            edgeLow = fineW'(centre - fw1'(halfW));
        end
    end

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            active    <= 1'b0;
            rdPixel   <= '0;
            peakValid <= 1'b0;
            readDone  <= 1'b0;
        end else begin
            peakValid <= step;
            // done one cycle after the last pixel
            readDone  <= peakValid && (peakPixel == lastPix);
            if (step) begin
                if (rdPixel == lastPix) begin
                    active  <= 1'b0;
                    rdPixel <= '0;
                end else begin
                    active  <= 1'b1;
                    rdPixel <= rdPixel + 1'b1;
                end
            end
        end
    end

    // result fields, qualified by peakValid
    always_ff @(posedge clk) begin
        if (step) begin
            peakPixel <= rdPixel;
            peakBin   <= rdBin;
            peakCount <= rdCount;
            windowLow <= edgeLow;
        end
    end

endmodule

`default_nettype wire

//--- peakTracker.sv
`timescale 1ns/10ps
`default_nettype none

module peakTracker import hisPkg::*; #(
    parameter int binW = DEF_BIN_W,
    parameter int countW = DEF_COUNT_W,
    parameter int pixelNum = DEF_PIXELS,
    localparam int pixW = (pixelNum > 1) ? $clog2(pixelNum) : 1
) (
    input  logic              clk,
    input  logic              combin_res,
    input  logic [pixW-1:0]   rdPixel,
    output logic [binW-1:0]   rdBin,
    output logic [countW-1:0] rdCount,
    binIf.slave               bin
);

    // running peak per pixel
    logic [countW-1:0] maxCnt [pixelNum];
    logic [binW-1:0]   maxBin [pixelNum];
    logic              higher;

    // strict compare, first bin to reach a count keeps it
    assign higher = bin.valid && (bin.count > maxCnt[bin.pixel]);

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            maxCnt <= '{default: '0};
            maxBin <= '{default: '0};
        end else if (bin.clear) begin
            // forwarded clear, histogram already empty
            maxCnt <= '{default: '0};
            maxBin <= '{default: '0};
        end else if (higher) begin
            maxCnt[bin.pixel] <= bin.count;
            maxBin[bin.pixel] <= bin.addr;
        end
    end

    // combinational read for the readout walk
    assign rdBin   = maxBin[rdPixel];
    assign rdCount = maxCnt[rdPixel];

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the histogram builder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f --top-module hisBuilderTb -o hisBuilderSim

./obj_dir/hisBuilderSim | tee sim.log

# the run passes only if the testbench printed the pass line
grep -q "^Test passed$" sim.log

//--- vlog.f
hisPkg.sv
hisIf.sv
acqSequencer.sv
binMemory.sv
peakTracker.sv
peakReadout.sv
hisBuilder.sv
hisBuilder_assertions.sv
hisBuilderTb.sv
